//--- channel_adder.f
+incdir+verif
rtl/channel_adder_pkg.sv
rtl/line_buffer.sv
rtl/channel_sequencer.sv
rtl/adder_tree.sv
rtl/channel_adder.sv
verif/channel_adder_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= channel_adder_tb
FILELIST  ?= channel_adder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard rtl/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Result: FAIL"; exit 1; \
	elif grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL, no result line in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/channel_adder_checks.svh
  ////////////////////////////////////////
  // Error counters

  int value_errors    = 0;
  int latency_errors  = 0;
  int count_errors    = 0;
  int protocol_errors = 0;

  ////////////////////////////////////////
  // Compare tasks

  task automatic check_sum(string name, sum_t expected, sum_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Fail %s sum at %0t: expected %0d, actual %0d", name, $time, expected, actual);
    end
  endtask

  // Cycles from the driving edge of the last-channel sample to sum_valid
  task automatic check_latency(string name, int expected, int actual);
    if (actual != expected) begin
      latency_errors++;
      $display("Fail %s latency at %0t: expected %0d, actual %0d", name, $time, expected, actual);
    end
  endtask

  task automatic check_count(string name, int expected, int actual);
    if (actual != expected) begin
      count_errors++;
      $display("Fail %s result count: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic report_problem(string msg);
    protocol_errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  function automatic int total_errors();
    return value_errors + latency_errors + count_errors + protocol_errors;
  endfunction

  task automatic print_error_counts();
    $display("Errors: value %0d, latency %0d, count %0d, protocol %0d",
             value_errors, latency_errors, count_errors, protocol_errors);
  endtask

//--- verif/channel_adder_tb.sv
`timescale 1ns/100ps

module channel_adder_tb
  import channel_adder_pkg::*;
();

  localparam int CLK_HALF     = 20;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_GAP      = 3;
  localparam int LATENCY      = 1 + TREE_LEVELS;
  localparam int DRAIN_LIMIT  = 4 * LATENCY;
  localparam int NUM_ROWS     = 6;

  localparam int KIND_ONES     = 0;
  localparam int KIND_RAMP     = 1;
  localparam int KIND_RANDOM   = 2;
  localparam int KIND_EXTREMES = 3;

  localparam pixel_t PIX_MAX = pixel_t'({1'b0, {(PIXEL_WIDTH-1){1'b1}}});
  localparam pixel_t PIX_MIN = pixel_t'({1'b1, {(PIXEL_WIDTH-1){1'b0}}});

  typedef struct {
    string name;
    int    groups;
    int    kind;
    int    gap_pct;
  } test_row_t;

  logic   clk;
  logic   reset;
  logic   pixel_valid;
  pixel_t pixel;
  logic   sum_valid;
  sum_t   sum;

  test_row_t rows [NUM_ROWS];
  logic      table_ready;
  integer    seed;
  int        cycle_cnt;
  int        row_results;
  string     cur_name;

  // One group of samples, indexed by channel and position
  pixel_t group_data [CHANNEL_NUM][FRAME_LEN];
  sum_t   exp_q [$];
  int     cycle_q [$];
  sum_t   mon_exp;
  int     mon_cycle;

  `include "channel_adder_checks.svh"

  channel_adder uut (
    .clk         (clk),
    .reset       (reset),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    .sum_valid   (sum_valid),
    .sum         (sum)
  );

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////
  // Stimulus table

  task automatic build_table();
    rows[0] = '{"ones_align", 2, KIND_ONES, 0};
    rows[1] = '{"ramp_align", 2, KIND_RAMP, 0};
    rows[2] = '{"random_values", 3, KIND_RANDOM, 0};
    rows[3] = '{"extreme_values", 2, KIND_EXTREMES, 0};
    rows[4] = '{"random_gaps", 3, KIND_RANDOM, 30};
    rows[5] = '{"back_to_back", 4, KIND_RAMP, 0};
  endtask

  function automatic pixel_t make_sample(int kind, int g, int ch, int p);
    pixel_t val;
    case (kind)
      KIND_ONES:   val = pixel_t'(1);
      KIND_RAMP:   val = pixel_t'(ch * 100 + p * 7 + g - 300);
      KIND_RANDOM: val = pixel_t'($random(seed));
      default: begin
        // Full-scale columns of both signs, then mixed ones
        case (p % 4)
          0:       val = PIX_MAX;
          1:       val = PIX_MIN;
          2:       val = ch[0] ? PIX_MAX : PIX_MIN;
          default: val = ($random(seed) % 2 == 0) ? PIX_MAX : PIX_MIN;
        endcase
      end
    endcase
    return val;
  endfunction

  // Reference sum over all channels of the group at one position
  function automatic sum_t model_sum(int p);
    int acc;
    acc = 0;
    for (int ch = 0; ch < CHANNEL_NUM; ch++) begin
      acc += int'(group_data[ch][p]);
    end
    return sum_t'(acc);
  endfunction

  function automatic int gap_cycles(int pct);
    int roll;
    roll = int'($unsigned($random(seed)) % 100);
    if (roll >= pct) begin
      return 0;
    end
    return 1 + int'($unsigned($random(seed)) % MAX_GAP);
  endfunction

  ////////////////////////////////////////
  // Driver

  task automatic drive_sample(pixel_t value, int gap_pct);
    int idle;
    idle = gap_cycles(gap_pct);
    repeat (idle) begin
      @(negedge clk);
      pixel_valid = 1'b0;
    end
    @(negedge clk);
    pixel_valid = 1'b1;
    pixel       = value;
  endtask

  task automatic run_row(test_row_t row);
    int drain_cnt;
    for (int g = 0; g < row.groups; g++) begin
      for (int ch = 0; ch < CHANNEL_NUM; ch++) begin
        for (int p = 0; p < FRAME_LEN; p++) begin
          group_data[ch][p] = make_sample(row.kind, g, ch, p);
        end
      end
      for (int ch = 0; ch < CHANNEL_NUM; ch++) begin
        for (int p = 0; p < FRAME_LEN; p++) begin
          drive_sample(group_data[ch][p], row.gap_pct);
          if (ch == CHANNEL_NUM - 1) begin
            exp_q.push_back(model_sum(p));
            cycle_q.push_back(cycle_cnt);
          end
        end
      end
    end
    @(negedge clk);
    pixel_valid = 1'b0;
    drain_cnt   = 0;
    while (exp_q.size() != 0 && drain_cnt < DRAIN_LIMIT) begin
      @(negedge clk);
      drain_cnt++;
    end
    // A few idle cycles to catch stray results
    repeat (LATENCY) @(negedge clk);
    check_count(row.name, row.groups * FRAME_LEN, row_results);
  endtask

  ////////////////////////////////////////
  // Monitor

  always @(negedge clk) begin
    if (reset === 1'b0) begin
      if (sum_valid === 1'b1) begin
        row_results++;
        if (exp_q.size() == 0) begin
          report_problem($sformatf("sum_valid high with no result pending in %s", cur_name));
        end else begin
          mon_exp   = exp_q.pop_front();
          mon_cycle = cycle_q.pop_front();
          check_sum(cur_name, mon_exp, sum);
          check_latency(cur_name, LATENCY, cycle_cnt - mon_cycle);
        end
      end else if (sum_valid !== 1'b0) begin
        report_problem("sum_valid is unknown after reset");
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    pixel_valid = 1'b0;
    pixel       = '0;
    seed        = 32'h0a08_e6f6;
    cycle_cnt   = 0;
    row_results = 0;
    cur_name    = "reset";
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_name    = rows[r].name;
      row_results = 0;
      run_row(rows[r]);
    end
    if (exp_q.size() != 0) begin
      report_problem($sformatf("%0d expected sums never appeared", exp_q.size()));
    end
    print_error_counts();
    if (total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Worst case every sample carries a full gap
  initial begin
    longint samples;
    longint limit_ns;
    wait (table_ready === 1'b1);
    samples = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      samples += rows[r].groups * CHANNEL_NUM * FRAME_LEN;
    end
    limit_ns = (samples * (1 + MAX_GAP) + 100) * 2 * CLK_HALF;
    #(limit_ns);
    $display("Timeout: run did not finish within %0d ns", limit_ns);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- rtl/channel_adder.sv
`timescale 1ns/100ps

module channel_adder
  import channel_adder_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   pixel_valid,
  input  pixel_t pixel,
  output logic   sum_valid,
  output sum_t   sum
);

  ////////////////////////////////////////
  // Line buffer chain

  // Tap k holds the same position from k channels back
  pixel_t                 tap [CHANNEL_NUM];
  logic [CHANNEL_NUM-1:0] tap_valid;

  assign tap[0]       = pixel;
  assign tap_valid[0] = pixel_valid;

  for (genvar k = 0; k < CHANNEL_NUM - 1; k++) begin : g_line
    line_buffer u_line_buffer (
      .clk       (clk),
      .reset     (reset),
      .valid_in  (tap_valid[k]),
      .data_in   (tap[k]),
      .valid_out (tap_valid[k+1]),
      .data_out  (tap[k+1])
    );
  end

  ////////////////////////////////////////
  // Group position

  logic last_channel;

  channel_sequencer u_channel_sequencer (
    .clk          (clk),
    .reset        (reset),
    .pixel_valid  (pixel_valid),
    .last_channel (last_channel)
  );

  ////////////////////////////////////////
  // Tap register

  logic [CHANNEL_NUM*PIXEL_WIDTH-1:0] taps;
  logic                               taps_valid;
  logic                               taps_load;

  // Deepest tap valid also confirms the whole chain has filled
  assign taps_load = pixel_valid && last_channel && tap_valid[CHANNEL_NUM-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      taps_valid <= 1'b0;
    end else begin
      taps_valid <= taps_load;
    end
  end

  always_ff @(posedge clk) begin
    if (taps_load) begin
      for (int k = 0; k < CHANNEL_NUM; k++) begin
        taps[k*PIXEL_WIDTH +: PIXEL_WIDTH] <= tap[k];
      end
    end
  end

  ////////////////////////////////////////
  // Channel sum

  adder_tree u_adder_tree (
    .clk        (clk),
    .reset      (reset),
    .taps_valid (taps_valid),
    .taps       (taps),
    .sum_valid  (sum_valid),
    .sum        (sum)
  );

endmodule

//--- rtl/adder_tree.sv
`timescale 1ns/100ps

module adder_tree
  import channel_adder_pkg::*;
(
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           taps_valid,
  input  logic [CHANNEL_NUM*PIXEL_WIDTH-1:0] taps,
  output logic                           sum_valid,
  output sum_t                           sum
);

  ////////////////////////////////////////
  // Leaves and level storage

  pixel_t leaf [CHANNEL_NUM];

  // Level l keeps CHANNEL_NUM >> l partial sums, upper entries unused
  sum_t node [1:TREE_LEVELS][CHANNEL_NUM];

  // Bit l-1 marks the results held in level l
  logic [TREE_LEVELS-1:0] level_valid;

  for (genvar i = 0; i < CHANNEL_NUM; i++) begin : g_leaf
    assign leaf[i] = taps[i*PIXEL_WIDTH +: PIXEL_WIDTH];
  end

  ////////////////////////////////////////
  // Adder levels

  for (genvar l = 1; l <= TREE_LEVELS; l++) begin : g_level
    // Operand width of this level and the pairing distance
    localparam int IN_W = PIXEL_WIDTH + l - 1;
    localparam int HALF = CHANNEL_NUM >> l;

    logic in_valid;

    if (l == 1) begin : g_first_valid
      assign in_valid = taps_valid;
    end else begin : g_next_valid
      assign in_valid = level_valid[l-2];
    end

    for (genvar i = 0; i < HALF; i++) begin : g_node
      logic signed [IN_W-1:0] op_a;
      logic signed [IN_W-1:0] op_b;
      logic signed [IN_W:0]   ext_a;
      logic signed [IN_W:0]   ext_b;

      // Element i pairs with element i + HALF
      if (l == 1) begin : g_from_taps
        assign op_a = leaf[i];
        assign op_b = leaf[i+HALF];
      end else begin : g_from_level
        assign op_a = node[l-1][i][IN_W-1:0];
        assign op_b = node[l-1][i+HALF][IN_W-1:0];
      end

      // One guard bit per level, the add cannot wrap
      assign ext_a = op_a;
      assign ext_b = op_b;

      always_ff @(posedge clk) begin
        if (in_valid) begin
          node[l][i] <= ext_a + ext_b;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Valid pipeline

  always_ff @(posedge clk) begin
    if (reset) begin
      level_valid <= '0;
    end else begin
      level_valid <= {level_valid[TREE_LEVELS-2:0], taps_valid};
    end
  end

  assign sum       = node[TREE_LEVELS][0];
  assign sum_valid = level_valid[TREE_LEVELS-1];

endmodule

//--- rtl/channel_sequencer.sv
`timescale 1ns/100ps

module channel_sequencer
  import channel_adder_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic pixel_valid,
  output logic last_channel
);

  ////////////////////////////////////////
  // Counters

  pixel_cnt_t   pixel_cnt;
  channel_cnt_t channel_cnt;
  logic         frame_end;

  // Last position of the current channel frame
  assign frame_end = pixel_valid && (pixel_cnt == pixel_cnt_t'(FRAME_LEN - 1));

  // Position within the frame, held across gaps
  always_ff @(posedge clk) begin
    if (reset) begin
      pixel_cnt <= '0;
    end else if (pixel_valid) begin
      if (frame_end) begin
        pixel_cnt <= '0;
      end else begin
        pixel_cnt <= pixel_cnt + 1'b1;
      end
    end
  end

  // Channel index within the group
  always_ff @(posedge clk) begin
    if (reset) begin
      channel_cnt <= '0;
    end else if (frame_end) begin
      if (channel_cnt == channel_cnt_t'(CHANNEL_NUM - 1)) begin
        channel_cnt <= '0;
      end else begin
        channel_cnt <= channel_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Decode

  // High for every sample of the final channel in a group
  assign last_channel = (channel_cnt == channel_cnt_t'(CHANNEL_NUM - 1));

endmodule

//--- rtl/line_buffer.sv
`timescale 1ns/100ps

module line_buffer
  import channel_adder_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   valid_in,
  input  pixel_t data_in,
  output logic   valid_out,
  output pixel_t data_out
);

  ////////////////////////////////////////
  // Storage

  pixel_t     shift_reg [FRAME_LEN];
  pixel_cnt_t fill_cnt;
  logic       filled;

  // Shifts only on accepted samples, so gaps leave the frame intact
  always_ff @(posedge clk) begin
    if (valid_in) begin
      shift_reg[0] <= data_in;
      for (int k = 1; k < FRAME_LEN; k++) begin
        shift_reg[k] <= shift_reg[k-1];
      end
    end
  end

  ////////////////////////////////////////
  // Fill tracking

  // Counts the first frame in, then stays filled until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      fill_cnt <= '0;
      filled   <= 1'b0;
    end else if (valid_in && !filled) begin
      fill_cnt <= fill_cnt + 1'b1;
      if (fill_cnt == pixel_cnt_t'(FRAME_LEN - 1)) begin
        filled <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Output

  // Oldest stored word lines up with the sample now at data_in,
  // so the next stage shifts on the same edge and the taps stay aligned
  assign data_out  = shift_reg[FRAME_LEN-1];
  assign valid_out = valid_in && filled;

endmodule

//--- rtl/channel_adder_pkg.sv
package channel_adder_pkg;

  ////////////////////////////////////////
  // Geometry

  // Channels summed into one output sample, a power of two
  localparam int CHANNEL_NUM = 8;

  // One adder level per halving of the channel count
  localparam int TREE_LEVELS = $clog2(CHANNEL_NUM);

  // Samples per channel frame
  localparam int FRAME_LEN = 16;

  ////////////////////////////////////////
  // Data widths

  localparam int PIXEL_WIDTH = 16;

  // One extra bit per tree level keeps the sum exact
  localparam int SUM_WIDTH = PIXEL_WIDTH + TREE_LEVELS;

  localparam int PIXEL_CNT_WIDTH   = $clog2(FRAME_LEN);
  localparam int CHANNEL_CNT_WIDTH = $clog2(CHANNEL_NUM);

  ////////////////////////////////////////
  // Types

  typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;
  typedef logic signed [SUM_WIDTH-1:0]   sum_t;

  typedef logic [PIXEL_CNT_WIDTH-1:0]   pixel_cnt_t;
  typedef logic [CHANNEL_CNT_WIDTH-1:0] channel_cnt_t;

endpackage
